//--- design/rv_issue_config.svh
`ifndef RV_ISSUE_CONFIG_SVH
`define RV_ISSUE_CONFIG_SVH

// data and instruction word width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// cycles a destination stays busy once its producer issues
// covers the execute and result stages ahead of the file write
`define RV_PEND_CYCLES 2

// instruction slots dropped behind a taken branch
`define RV_KILL_SLOTS 2

`endif

//--- design/rv_isa_pkg.sv
`include "rv_issue_config.svh"

package rv_isa_pkg;

	typedef logic [`RV_XLEN-1:0] word_t; // data or instruction word

	typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

	// wide enough to hold the full pending latency
	typedef logic [$clog2(`RV_PEND_CYCLES+1)-1:0] pend_cnt_t;

	// major opcodes handled by the decoder
	typedef enum logic [6:0]
	{
		OPC_LUI    = 7'b0110111,
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	// what the operation reads and writes
	typedef enum logic [2:0]
	{
		CLS_NOP    = 3'd0, // no sources, no destination
		CLS_ALU_RR = 3'd1, // rs1, rs2 -> rd
		CLS_ALU_RI = 3'd2, // rs1, imm -> rd
		CLS_UPPER  = 3'd3, // imm -> rd
		CLS_BRANCH = 3'd4  // rs1, rs2 compare only
	} op_class_e;

	typedef enum logic [1:0]
	{
		FN_ADD = 2'd0,
		FN_SUB = 2'd1,
		FN_BEQ = 2'd2,
		FN_BNE = 2'd3
	} alu_fn_e;

endpackage

//--- design/rv_pipe_pkg.sv
package rv_pipe_pkg;

	// decoded instruction with its source operands already read
	typedef struct packed
	{
		logic                  valid;
		rv_isa_pkg::op_class_e cls;
		rv_isa_pkg::alu_fn_e   fn;
		rv_isa_pkg::reg_idx_t  rd;
		rv_isa_pkg::reg_idx_t  rs1;
		rv_isa_pkg::reg_idx_t  rs2;
		logic                  uses_rs1;
		logic                  uses_rs2;
		logic                  writes_rd; // low for rd == x0
		rv_isa_pkg::word_t     a;         // rs1 value
		rv_isa_pkg::word_t     b;         // rs2 value
		rv_isa_pkg::word_t     imm;
	} dec_op_t;

	// execute output toward the result stage
	typedef struct packed
	{
		logic                 valid;
		logic                 writes_rd;
		rv_isa_pkg::reg_idx_t rd;
		rv_isa_pkg::word_t    value;
	} exe_res_t;

	// register file write, also reported at the top
	typedef struct packed
	{
		logic                 valid;
		rv_isa_pkg::reg_idx_t rd;
		rv_isa_pkg::word_t    data;
	} wb_t;

endpackage

//--- design/rv_decode.sv
`timescale 1ns/1ps
`include "rv_issue_config.svh"

module rv_decode
(
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  instr_valid,
	input  rv_isa_pkg::word_t     instr,
	input  rv_pipe_pkg::wb_t      wb,
	output rv_pipe_pkg::dec_op_t  dec
);

	import rv_isa_pkg::*;

	opcode_e   opc;
	reg_idx_t  rd;
	reg_idx_t  rs1;
	reg_idx_t  rs2;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t     imm_i;
	word_t     imm_u;
	op_class_e cls;
	alu_fn_e   fn;

	word_t rf [`RV_NREGS];

	assign opc    = opcode_e'(instr[6:0]);
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};

	// anything not recognised falls through as a nop
	always_comb
	begin
		cls = CLS_NOP;
		fn  = FN_ADD;
		case (opc)
			OPC_LUI: cls = CLS_UPPER;
			OPC_OP:
			begin
				if (funct3 == 3'b000 && funct7 == 7'h00)
				begin
					cls = CLS_ALU_RR;
				end
				else if (funct3 == 3'b000 && funct7 == 7'h20)
				begin
					cls = CLS_ALU_RR;
					fn  = FN_SUB;
				end
			end
			OPC_OP_IMM:
			begin
				if (funct3 == 3'b000)
					cls = CLS_ALU_RI; // addi only
			end
			OPC_BRANCH:
			begin
				if (funct3 == 3'b000)
				begin
					cls = CLS_BRANCH;
					fn  = FN_BEQ;
				end
				else if (funct3 == 3'b001)
				begin
					cls = CLS_BRANCH;
					fn  = FN_BNE;
				end
			end
			default: cls = CLS_NOP;
		endcase
	end

	always_comb
	begin
		dec.valid     = instr_valid;
		dec.cls       = cls;
		dec.fn        = fn;
		dec.rd        = rd;
		dec.rs1       = rs1;
		dec.rs2       = rs2;
		dec.uses_rs1  = cls inside {CLS_ALU_RR, CLS_ALU_RI, CLS_BRANCH};
		dec.uses_rs2  = cls inside {CLS_ALU_RR, CLS_BRANCH};
		dec.writes_rd = (cls inside {CLS_ALU_RR, CLS_ALU_RI, CLS_UPPER}) && (rd != '0);
		dec.a         = (rs1 == '0) ? '0 : rf[rs1]; // x0 reads zero
		dec.b         = (rs2 == '0) ? '0 : rf[rs2];
		if (cls == CLS_UPPER)
			dec.imm = imm_u;
		else if (cls == CLS_ALU_RI)
			dec.imm = imm_i;
		else
			dec.imm = '0;
	end

	// register file, read above without bypass
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `RV_NREGS; i++)
				rf[i] <= '0;
		end
		else if (wb.valid && wb.rd != '0)
		begin
			rf[wb.rd] <= wb.data;
		end
	end

endmodule

//--- design/rv_scoreboard.sv
`timescale 1ns/1ps
`include "rv_issue_config.svh"

module rv_scoreboard
(
	input  logic                  clk,
	input  logic                  nrst,
	input  rv_pipe_pkg::dec_op_t  dec,
	input  logic                  btaken,
	output logic                  issue,
	output logic                  stall,
	output logic                  kill,
	output rv_isa_pkg::pend_cnt_t stall_cycles
);

	import rv_isa_pkg::*;

	// cycles left until each register's pending write lands
	pend_cnt_t pend [`RV_NREGS];

	pend_cnt_t cnt_rs1;
	pend_cnt_t cnt_rs2;
	pend_cnt_t cnt_max;
	logic      hazard;

	logic [1:0] kill_cnt; // kill slots still to drop after the branch cycle

	// only the sources the instruction really reads count
	always_comb
	begin
		cnt_rs1 = dec.uses_rs1 ? pend[dec.rs1] : '0;
		cnt_rs2 = dec.uses_rs2 ? pend[dec.rs2] : '0;
		cnt_max = (cnt_rs1 > cnt_rs2) ? cnt_rs1 : cnt_rs2;
		hazard  = dec.valid && (cnt_max != '0);
	end

	assign kill  = btaken || (kill_cnt != '0);
	assign stall = hazard && !kill; // kill wins over stall
	assign issue = dec.valid && !stall && !kill;

	assign stall_cycles = stall ? cnt_max : '0;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `RV_NREGS; i++)
				pend[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `RV_NREGS; i++)
			begin
				// a new producer restarts the count
				if (issue && dec.writes_rd && dec.rd == reg_idx_t'(i))
					pend[i] <= pend_cnt_t'(`RV_PEND_CYCLES);
				else if (pend[i] != '0)
					pend[i] <= pend[i] - 1'b1;
			end
		end
	end

	// tail of the kill window after btaken drops
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			kill_cnt <= '0;
		end
		else if (btaken)
		begin
			kill_cnt <= 2'(`RV_KILL_SLOTS - 1);
		end
		else if (kill_cnt != '0)
		begin
			kill_cnt <= kill_cnt - 1'b1;
		end
	end

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ps

module rv_execute
(
	input  logic                  clk,
	input  logic                  nrst,
	input  rv_pipe_pkg::dec_op_t  dec,
	input  logic                  issue,
	output logic                  btaken,
	output rv_pipe_pkg::exe_res_t ex_res
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	logic    op_valid;
	dec_op_t op_q;    // issued operation, payload only
	word_t   value;
	logic    equal;
	logic    taken;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			op_valid <= 1'b0;
		else
			op_valid <= issue;
	end

	always_ff @(posedge clk)
	begin
		if (issue)
			op_q <= dec;
	end

	// ALU
	always_comb
	begin
		case (op_q.cls)
			CLS_ALU_RR:
			begin
				if (op_q.fn == FN_SUB)
					value = op_q.a - op_q.b;
				else
					value = op_q.a + op_q.b;
			end
			CLS_ALU_RI: value = op_q.a + op_q.imm;
			CLS_UPPER:  value = op_q.imm; // lui
			default:    value = '0;
		endcase
	end

	// branch compare
	always_comb
	begin
		equal = (op_q.a == op_q.b);
		taken = 1'b0;
		if (op_q.cls == CLS_BRANCH)
			taken = (op_q.fn == FN_BNE) ? !equal : equal;
	end

	assign btaken = op_valid && taken;

	always_comb
	begin
		ex_res.valid     = op_valid;
		ex_res.writes_rd = op_q.writes_rd;
		ex_res.rd        = op_q.rd;
		ex_res.value     = value;
	end

endmodule

//--- design/rv_result.sv
`timescale 1ns/1ps

module rv_result
(
	input  logic                  clk,
	input  logic                  nrst,
	input  rv_pipe_pkg::exe_res_t ex_res,
	output rv_pipe_pkg::wb_t      wb
);

	import rv_pipe_pkg::*;

	logic     res_valid;
	exe_res_t res_q;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			res_valid <= 1'b0;
		else
			res_valid <= ex_res.valid;
	end

	always_ff @(posedge clk)
	begin
		if (ex_res.valid)
			res_q <= ex_res;
	end

	// branches and nops end here, so wb.valid always means a register changed
	// the file takes this write on the next edge
	always_comb
	begin
		wb.valid = res_valid && res_q.writes_rd;
		wb.rd    = res_q.rd;
		wb.data  = res_q.value;
	end

endmodule

//--- design/rv_issue_core.sv
`timescale 1ns/1ps

module rv_issue_core
(
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  instr_valid,
	input  rv_isa_pkg::word_t     instr,
	output logic                  stall,
	output logic                  kill,
	output rv_isa_pkg::pend_cnt_t stall_cycles,
	output rv_pipe_pkg::wb_t      wb
);

	import rv_pipe_pkg::*;

	dec_op_t  dec;
	exe_res_t ex_res;
	logic     issue;
	logic     btaken;

	rv_decode rv_decode_i
	(
		.clk         (clk),
		.nrst        (nrst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),
		.dec         (dec)
	);

	rv_scoreboard rv_scoreboard_i
	(
		.clk          (clk),
		.nrst         (nrst),
		.dec          (dec),
		.btaken       (btaken),
		.issue        (issue),
		.stall        (stall),
		.kill         (kill),
		.stall_cycles (stall_cycles)
	);

	rv_execute rv_execute_i
	(
		.clk    (clk),
		.nrst   (nrst),
		.dec    (dec),
		.issue  (issue),
		.btaken (btaken),
		.ex_res (ex_res)
	);

	rv_result rv_result_i
	(
		.clk    (clk),
		.nrst   (nrst),
		.ex_res (ex_res),
		.wb     (wb)
	);

endmodule

//--- sim/rv_issue_core_tb.sv
`timescale 1ns/1ps

module rv_issue_core_tb;

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	localparam int rand_len        = 300;
	localparam int max_words       = rand_len + 40; // directed programs included
	localparam int watchdog_cycles = max_words * 4 + 200;

	logic      clk         = 1'b0;
	logic      nrst        = 1'b0;
	logic      instr_valid = 1'b0;
	word_t     instr       = '0;
	logic      stall;
	logic      kill;
	pend_cnt_t stall_cycles;
	wb_t       wb;

	word_t       prog[$];
	logic [36:0] expected[$]; // {rd, data} in write-back order
	logic [36:0] exp_wb;
	word_t       model_rf [32];
	logic [63:0] killed_mask; // bit per word consumed under kill
	int          trace_idx;
	int          trace_code;  // one octal digit {stall, stall_cycles} per cycle
	int          trace_len;
	int          errors       = 0;
	int          err_before;
	int          tests_run    = 0;
	int          tests_failed = 0;
	string       cur_test     = "reset";

	rv_issue_core rv_issue_core_i
	(
		.clk          (clk),
		.nrst         (nrst),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.stall        (stall),
		.kill         (kill),
		.stall_cycles (stall_cycles),
		.wb           (wb)
	);

	always #5 clk = ~clk;

	function automatic word_t alu_rr_word(input logic sub, input reg_idx_t rd,
		input reg_idx_t rs1, input reg_idx_t rs2);
		return {1'b0, sub, 5'b00000, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction

	function automatic word_t addi_word(input reg_idx_t rd, input reg_idx_t rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic word_t lui_word(input reg_idx_t rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	// f3 0 is beq, 1 is bne; the offset plays no part here
	function automatic word_t branch_word(input logic [2:0] f3, input reg_idx_t rs1,
		input reg_idx_t rs2);
		return {7'h00, rs2, rs1, f3, 5'b01000, 7'b1100011};
	endfunction

	function automatic word_t random_word();
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		rd  = reg_idx_t'($urandom % 4); // x0..x3 keeps hazards frequent
		rs1 = reg_idx_t'($urandom % 4);
		rs2 = reg_idx_t'($urandom % 4);
		case ($urandom % 8)
			0:       return lui_word(rd, 20'($urandom));
			1:       return alu_rr_word(1'b0, rd, rs1, rs2);
			2:       return alu_rr_word(1'b1, rd, rs1, rs2);
			3, 4:    return addi_word(rd, rs1, 12'($urandom));
			5:       return branch_word(3'b000, rs1, rs2);
			6:       return branch_word(3'b001, rs1, rs2);
			// load opcode decodes as a nop
			default: return (word_t'($urandom) & 32'hffff_ff80) | 32'h0000_0003;
		endcase
	endfunction

	// sequential ISA model that appends each register change to expected
	function automatic void ref_execute();
		int         i;
		word_t      w;
		word_t      a;
		word_t      b;
		word_t      val;
		logic [2:0] f3;
		logic       wr;
		i = 0;
		while (i < prog.size())
		begin
			w  = prog[i];
			a  = model_rf[w[19:15]];
			b  = model_rf[w[24:20]];
			f3 = w[14:12];
			i++;
			case (w[6:0])
				7'b0110111: val = {w[31:12], 12'h000};
				7'b0110011: val = w[30] ? a - b : a + b;
				7'b0010011: val = a + {{20{w[31]}}, w[31:20]};
				default:    val = '0;
			endcase
			wr = (w[6:0] == 7'b0110111)
				|| (w[6:0] == 7'b0110011 && f3 == 3'b000
					&& (w[31:25] == 7'h00 || w[31:25] == 7'h20))
				|| (w[6:0] == 7'b0010011 && f3 == 3'b000);
			if (w[6:0] == 7'b1100011
				&& ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)))
				i += 2; // both slots behind a taken branch are dropped
			if (wr && w[11:7] != 5'd0)
			begin
				model_rf[w[11:7]] = val;
				expected.push_back({w[11:7], val});
			end
		end
	endfunction

	// feeds prog back to back and holds a word while stall is high
	task automatic run_program(input string name, input int traced);
		int   idx;
		int   wait_cnt;
		logic was_stall;
		logic was_kill;
		cur_test    = name;
		err_before  = errors;
		trace_idx   = traced;
		trace_code  = 0;
		trace_len   = 0;
		killed_mask = '0;
		ref_execute();
		idx = 0;
		while (idx < prog.size())
		begin
			instr_valid = 1'b1;
			instr       = prog[idx];
			@(negedge clk);
			was_stall = stall;
			was_kill  = kill;
			if (idx == trace_idx)
			begin
				trace_code = trace_code * 8 + {stall, stall_cycles};
				trace_len++;
			end
			@(posedge clk);
			#1;
			if (was_kill || !was_stall)
			begin
				if (was_kill && idx < 64)
					killed_mask[idx] = 1'b1;
				idx++;
			end
		end
		instr_valid = 1'b0;
		wait_cnt    = 0;
		while (expected.size() != 0 && wait_cnt < 20)
		begin
			@(posedge clk);
			wait_cnt++;
		end
		repeat (4) @(posedge clk); // room for a stray extra write-back
		#1;
		if (expected.size() != 0)
		begin
			$display("%s: %0d expected write-backs never arrived", cur_test,
				expected.size());
			errors++;
			expected.delete();
		end
		prog.delete();
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == err_before)
		begin
			$display("test %s: ok", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - err_before);
		end
	endtask

	// every write-back against the next reference entry
	always @(negedge clk)
	begin
		if (wb.valid)
		begin
			if (expected.size() == 0)
			begin
				$display("%s: write-back to x%0d that the program does not make",
					cur_test, wb.rd);
				errors++;
			end
			else
			begin
				exp_wb = expected.pop_front();
				if ({wb.rd, wb.data} !== exp_wb)
				begin
					$display("ERROR %s: expected x%0d=%h, actual x%0d=%h", cur_test,
						exp_wb[36:32], exp_wb[31:0], wb.rd, wb.data);
					errors++;
				end
			end
		end
	end

	initial
	begin
		void'($urandom(32'hb7cda428));
		model_rf = '{default: '0};
		repeat (10) @(posedge clk);
		#1;
		nrst = 1'b1;

		prog = '{lui_word(5'd1, 20'habcde), addi_word(5'd2, 5'd0, 12'hffb),
			addi_word(5'd3, 5'd0, 12'd100), lui_word(5'd4, 20'h00001),
			alu_rr_word(1'b0, 5'd5, 5'd1, 5'd2), alu_rr_word(1'b1, 5'd6, 5'd3, 5'd2)};
		run_program("independent_alu", -1);
		finish_test();

		// consumer right behind its producer waits 2 then 1 cycle
		prog = '{addi_word(5'd5, 5'd0, 12'd7), alu_rr_word(1'b0, 5'd6, 5'd5, 5'd5),
			alu_rr_word(1'b1, 5'd7, 5'd0, 5'd6)};
		run_program("raw_stall", 1);
		if (trace_code != 'o650 || trace_len != 3)
		begin
			$display("ERROR %s: expected stall trace 650 over 3 cycles, actual %o over %0d",
				cur_test, trace_code, trace_len);
			errors++;
		end
		finish_test();

		prog = '{addi_word(5'd0, 5'd0, 12'd5), addi_word(5'd4, 5'd0, 12'd1),
			lui_word(5'd0, 20'h12345), alu_rr_word(1'b0, 5'd0, 5'd4, 5'd4),
			alu_rr_word(1'b0, 5'd2, 5'd0, 5'd0), alu_rr_word(1'b1, 5'd3, 5'd4, 5'd0)};
		run_program("x0_handling", 1);
		if (trace_code != 0 || trace_len != 1)
		begin
			$display("ERROR %s: expected stall trace 0 over 1 cycle, actual %o over %0d",
				cur_test, trace_code, trace_len);
			errors++;
		end
		finish_test();

		// taken beq at 2, not-taken bne at 6, taken bne at 9
		prog = '{addi_word(5'd8, 5'd0, 12'd3), addi_word(5'd9, 5'd0, 12'd3),
			branch_word(3'b000, 5'd8, 5'd9), addi_word(5'd10, 5'd0, 12'd1),
			addi_word(5'd11, 5'd0, 12'd2), addi_word(5'd12, 5'd0, 12'd5),
			branch_word(3'b001, 5'd8, 5'd9), addi_word(5'd13, 5'd0, 12'd6),
			addi_word(5'd14, 5'd0, 12'd7), branch_word(3'b001, 5'd8, 5'd12),
			lui_word(5'd15, 20'h0beef), alu_rr_word(1'b0, 5'd16, 5'd8, 5'd8),
			alu_rr_word(1'b1, 5'd17, 5'd12, 5'd8)};
		run_program("branch_kill", -1);
		if (killed_mask != 64'h0c18)
		begin
			$display("ERROR %s: expected killed slots %h, actual %h", cur_test, 64'h0c18,
				killed_mask);
			errors++;
		end
		finish_test();

		repeat (rand_len)
			prog.push_back(random_word());
		run_program("random_program", -1);
		finish_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		#(watchdog_cycles * 10);
		$display("timeout: run still busy after %0d cycles", watchdog_cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- rv_issue_core.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_decode.sv
design/rv_scoreboard.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_issue_core.sv
sim/rv_issue_core_tb.sv

//--- Bender.yml
package:
  name: rv_issue_core

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/rv_pipe_pkg.sv
      - design/rv_decode.sv
      - design/rv_scoreboard.sv
      - design/rv_execute.sv
      - design/rv_result.sv
      - design/rv_issue_core.sv
  - target: test
    files:
      - sim/rv_issue_core_tb.sv
